// File: Makefile
# Verilator build and run of the TCP listener testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal --top-module tcp_listener_tb -f tcp_listener.f \
		-Mdir obj_dir -o tcp_listener_sim

run: compile
	./obj_dir/tcp_listener_sim | tee sim.log
	@grep -qx ">>> PASS" sim.log || (echo "Simulation did not pass, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: dv/tcp_listener_tb.sv
`timescale 1ns/100ps

module tcp_listener_tb;

	import tcp_pkg::*;

	localparam int CYCLES_PER_RECORD = 200;
	localparam int IDLE_GAP          = 24;  // Window for a reply that must not come
	localparam int REPLY_WORDS       = 5;   // Header-only reply

	logic       clk;
	logic       rx_flag_rst;
	ip_rx_bus_t rx_l3;
	ip_tx_bus_t tx_l3;
	wb_req_t    wb_req;
	wb_rsp_t    wb_rsp;

	int errors      = 0;
	int checks      = 0;
	int cycle_count = 0;
	int cycle_limit = CYCLES_PER_RECORD;  // Reset budget, grows per record
	int fd;

	// Reply monitor
	logic [31:0] tx_words [$];
	logic [31:0] tx_dst;
	logic [15:0] tx_len;
	logic [7:0]  tx_proto;
	int          tx_starts      = 0;
	int          tx_commits     = 0;
	int          tx_start_index = 0;  // Word count seen when start rose

	// Segment currently under test
	string       seg_name;
	logic [31:0] seg_words [16];
	int          words_base;
	int          starts_base;
	int          commits_base;

	tcp_listener dut0 (
		.clk         (clk),
		.rx_flag_rst (rx_flag_rst),
		.rx_l3       (rx_l3),
		.tx_l3       (tx_l3),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns
	end

	//////////////////////////////////////////////////
	// Watchdog and reply monitor on the falling edge

	always @(negedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT never finished the record", cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (tx_l3.start) begin
			tx_starts++;
			tx_start_index = tx_words.size();  // Start rides on the first word
			tx_dst   = tx_l3.dst_ip;
			tx_len   = tx_l3.payload_len;
			tx_proto = tx_l3.protocol;
		end
		if (tx_l3.data_valid) begin
			tx_words.push_back(tx_l3.data);
			check_value({seg_name, " bytes_valid"}, 32'd4, tx_l3.bytes_valid);  // Whole words
		end
		if (tx_l3.commit)
			tx_commits++;
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	// Wishbone classic, request held until ack
	task automatic wb_cycle(input logic write, input logic [31:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat_w: wdata};
		@(negedge clk);
		while (!wb_rsp.ack)
			@(negedge clk);
		rdata = wb_rsp.dat_r;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic send_segment(input logic [31:0] src, input logic [15:0] phc,
			input logic [15:0] len, input int abort, input int nwords);
		int i;
		@(posedge clk);
		rx_l3.start              <= 1'b1;  // Start in a cycle of its own
		rx_l3.src_ip             <= src;
		rx_l3.payload_len        <= len;
		rx_l3.protocol_is_tcp    <= 1'b1;
		rx_l3.pseudo_header_csum <= phc;
		for (i = 0; i < nwords; i++) begin
			@(posedge clk);
			rx_l3.start       <= 1'b0;
			rx_l3.data_valid  <= 1'b1;
			rx_l3.bytes_valid <= 3'd4;
			rx_l3.data        <= seg_words[i];
		end
		@(posedge clk);
		rx_l3.start      <= 1'b0;
		rx_l3.data_valid <= 1'b0;
		rx_l3.commit     <= (abort == 0);
		rx_l3.drop       <= (abort != 0);  // L3 abort instead of commit
		@(posedge clk);
		rx_l3.commit <= 1'b0;
		rx_l3.drop   <= 1'b0;
	endtask

	task automatic check_reply;
		logic [31:0] exp_dst;
		logic [31:0] exp_word;
		logic [31:0] got;
		int          code;
		int          i;
		code = $fscanf(fd, "%h", exp_dst);
		while (tx_commits == commits_base)  // Watchdog covers a missing reply
			@(posedge clk);
		check_value({seg_name, " start count"}, 32'd1, tx_starts - starts_base);
		check_value({seg_name, " start position"}, words_base, tx_start_index);
		check_value({seg_name, " dst_ip"}, exp_dst, tx_dst);
		check_value({seg_name, " payload_len"}, 32'd20, tx_len);
		check_value({seg_name, " protocol"}, 32'd6, tx_proto);
		check_value({seg_name, " word count"}, REPLY_WORDS, tx_words.size() - words_base);
		for (i = 0; i < REPLY_WORDS; i++) begin
			code = $fscanf(fd, "%h", exp_word);
			got  = (words_base + i < tx_words.size()) ? tx_words[words_base + i] : 32'h0;
			check_value($sformatf("%s word %0d", seg_name, i), exp_word, got);
		end
	endtask

	task automatic check_no_reply;
		repeat (IDLE_GAP) @(posedge clk);
		check_value({seg_name, " reply count"}, 32'd0, tx_starts - starts_base);
	endtask

	//////////////////////////////////////////////////
	// Main sequence, one data file record at a time

	initial begin
		string       kind;
		string       name;
		string       rest;
		logic [31:0] adr;
		logic [31:0] val;
		logic [31:0] rd;
		logic [31:0] src;
		logic [15:0] phc;
		logic [15:0] len;
		int          abort;
		int          nwords;
		int          code;
		int          i;

		rx_l3       = '0;
		wb_req      = '0;
		rx_flag_rst = 1'b1;
		repeat (10) @(posedge clk);
		rx_flag_rst <= 1'b0;
		@(posedge clk);

		fd = $fopen("dv/tcp_listener_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file dv/tcp_listener_testdata.txt");
			errors++;
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				cycle_limit += CYCLES_PER_RECORD;
				if (kind[0] == "#") begin
					code = $fgets(rest, fd);  // Skip comment line
				end else if (kind == "W" || kind == "R") begin
					code = $fscanf(fd, "%s %h %h", name, adr, val);
					wb_cycle(kind == "W", adr, val, rd);
					if (kind == "R")
						check_value(name, val, rd);
				end else if (kind == "S") begin
					code = $fscanf(fd, "%s %h %h %h %d %d", seg_name, src, phc, len,
						abort, nwords);
					for (i = 0; i < nwords; i++) begin
						code = $fscanf(fd, "%h", val);
						seg_words[i] = val;
					end
					words_base   = tx_words.size();
					starts_base  = tx_starts;
					commits_base = tx_commits;
					send_segment(src, phc, len, abort, nwords);
				end else if (kind == "E") begin
					check_reply();
				end else if (kind == "N") begin
					check_no_reply();
				end else begin
					$display("Unknown record kind %s in the test data file", kind);
					errors++;
				end
			end
			$fclose(fd);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: dv/tcp_listener_testdata.txt
# W name adr data | R name adr expected | N = no reply may follow | all values hex
# S name src_ip pseudo_csum payload_len abort(0/1) nwords words | E dst_ip five reply words
W set_local_ip 00000000 0a000001
W set_isn 00000004 12340000
R local_ip_readback 00000000 0a000001
R isn_readback 00000004 12340000
W open_80 00000008 00010050
S syn_open_80 c0a80002 cac5 0014 0 5 c3500050 00001000 00000000 5002faf0 16a60000
E c0a80002 0050c350 12340000 00001001 50120400 fb510000
S syn_never_opened_23 c0a80002 cac5 0014 0 5 c3500017 00006000 00000000 5002faf0 c6de0000
E c0a80002 0017c350 12350000 00006001 50140400 ab870000
W open_8081 00000008 00011f91
W close_8081 00000008 00001f91
S syn_closed_8081 c0a80002 cac5 0014 0 5 c3501f91 00007000 00000000 5002faf0 97640000
E c0a80002 1f91c350 12360000 00007001 50140400 7c0c0000
# Row 0 filled by 80, 96, 112 and 128, so 144 is refused
W open_96 00000008 00010060
W open_112 00000008 00010070
W open_128 00000008 00010080
W open_144_row_full 00000008 00010090
S syn_open_96 c0a80002 cac5 0014 0 5 c3500060 00002000 00000000 5002faf0 06960000
E c0a80002 0060c350 12370000 00002001 50120400 eb3e0000
S syn_open_112 c0a80002 cac5 0014 0 5 c3500070 00003000 00000000 5002faf0 f6850000
E c0a80002 0070c350 12380000 00003001 50120400 db2d0000
S syn_open_128 c0a80002 cac5 0014 0 5 c3500080 00004000 00000000 5002faf0 e6750000
E c0a80002 0080c350 12390000 00004001 50120400 cb1c0000
S syn_full_row_144 c0a80002 cac5 0014 0 5 c3500090 00005000 00000000 5002faf0 d6650000
E c0a80002 0090c350 123a0000 00005001 50140400 bb090000
# Four drops, no replies
S bad_checksum c0a80002 cac5 0014 0 5 c3500050 00001000 00000000 5002faf0 16a70000
N
S truncated c0a80002 cac5 0014 0 3 c3500050 00001000 00000000
N
S l3_drop c0a80002 cac5 0014 1 5 c3500050 00001000 00000000 5002faf0 16a60000
N
S plain_ack c0a80002 cac5 0014 0 5 c3500050 00008000 12340001 5010faf0 94620000
N
R drop_count 0000000c 00000004
R isn_after_replies 00000004 123b0000

// File: include/tcp_config.svh
`ifndef TCP_CONFIG_SVH
`define TCP_CONFIG_SVH

// Open-port table geometry
`define PORT_BINS        16
`define PORT_WAYS        4
`define PORT_BIN_BITS    4     // Low port bits pick the row

// Pending replies
`define REPLY_FIFO_DEPTH 4
`define ISN_STEP         32'h0001_0000  // Added per reply

// TCP header without options
`define TCP_HDR_WORDS    4'd5
`define TCP_HDR_BYTES    16'd20
`define IP_PROTO_TCP     8'd6
`define TCP_WINDOW       16'd1024

// Wishbone register map, byte addresses
`define REG_LOCAL_IP     32'h0000_0000
`define REG_ISN          32'h0000_0004
`define REG_PORT_CMD     32'h0000_0008
`define REG_DROP_COUNT   32'h0000_000C

`endif

// File: logic/inet_checksum.sv
`timescale 1ns/100ps

module inet_checksum (
	input  logic        clk,
	input  logic        rx_flag_rst,
	input  logic        load,     // Restart the sum with din
	input  logic        process,  // Fold din into the running sum
	input  logic [31:0] din,
	output logic [15:0] csum
);

	logic [15:0] sum;
	logic [15:0] base;
	logic [17:0] add3;
	logic [16:0] fold1;
	logic [15:0] next_sum;

	always_comb begin
		base     = load ? 16'h0000 : sum;
		add3     = {2'b00, base} + {2'b00, din[31:16]} + {2'b00, din[15:0]};
		fold1    = {1'b0, add3[15:0]} + {15'b0, add3[17:16]};  // End-around carry
		next_sum = fold1[15:0] + {15'b0, fold1[16]};           // At most one more
	end

	always_ff @(posedge clk) begin
		if (rx_flag_rst)
			sum <= 16'h0000;
		else if (load || process)
			sum <= next_sum;
	end

	assign csum = ~sum;  // Zero over a segment with a correct checksum

endmodule

// File: logic/listener_regs.sv
`timescale 1ns/100ps
`include "tcp_config.svh"

module listener_regs (
	input  logic                clk,
	input  logic                rx_flag_rst,
	input  tcp_pkg::wb_req_t    wb_req,
	output tcp_pkg::wb_rsp_t    wb_rsp,
	output tcp_pkg::port_cmd_t  port_cmd,
	output logic [31:0]         local_ip,
	output logic [31:0]         isn,
	input  logic                reply_push,
	input  logic                seg_drop
);

	logic [15:0] drop_count;
	logic        wb_access;
	logic        wb_wr;
	logic [31:0] rd_data;

	// New cycle only when not acking this one already
	assign wb_access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
	assign wb_wr     = wb_access && wb_req.we;

	//////////////////////////////////////////////////
	// Read mux

	always_comb begin
		case (wb_req.adr)
			`REG_LOCAL_IP:   rd_data = local_ip;
			`REG_ISN:        rd_data = isn;
			`REG_DROP_COUNT: rd_data = {16'h0000, drop_count};
			default:         rd_data = 32'h0000_0000;  // Port command reads as zero
		endcase
	end

	//////////////////////////////////////////////////
	// Registers and bus response

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			wb_rsp     <= '0;
			port_cmd   <= '0;
			local_ip   <= 32'h0000_0000;
			isn        <= 32'h0000_0000;
			drop_count <= 16'h0000;
		end else begin
			wb_rsp.ack     <= wb_access;  // One-cycle ack pulse
			port_cmd.valid <= 1'b0;

			if (wb_access && !wb_req.we)
				wb_rsp.dat_r <= rd_data;

			if (seg_drop)
				drop_count <= drop_count + 16'd1;

			// Advance per reply, accepted by the FIFO or not
			if (reply_push)
				isn <= isn + `ISN_STEP;

			if (wb_wr) begin
				case (wb_req.adr)
					`REG_LOCAL_IP: local_ip <= wb_req.dat_w;
					`REG_ISN:      isn      <= wb_req.dat_w;  // Host write beats the step
					`REG_PORT_CMD: begin
						port_cmd.valid <= 1'b1;
						port_cmd.open  <= wb_req.dat_w[16];  // Set opens, clear closes
						port_cmd.port  <= wb_req.dat_w[15:0];
					end
					default: ;  // Drop counter is read only
				endcase
			end
		end
	end

endmodule

// File: logic/port_table.sv
`timescale 1ns/100ps
`include "tcp_config.svh"

module port_table (
	input  logic                clk,
	input  logic                rx_flag_rst,
	input  tcp_pkg::port_cmd_t  cmd,
	input  logic                query_valid,
	input  logic [15:0]         query_port,
	output logic                port_open
);

	logic [`PORT_WAYS-1:0] way_valid [`PORT_BINS];
	logic [15:0]           way_port  [`PORT_BINS][`PORT_WAYS];

	logic [`PORT_BIN_BITS-1:0]     cmd_row;
	logic [`PORT_BIN_BITS-1:0]     q_row;
	logic [`PORT_WAYS-1:0]         cmd_hit;       // Ways already holding cmd.port
	logic                          free_found;
	logic [$clog2(`PORT_WAYS)-1:0] free_way;
	logic                          q_hit;

	always_comb begin
		cmd_row    = cmd.port[`PORT_BIN_BITS-1:0];
		q_row      = query_port[`PORT_BIN_BITS-1:0];
		free_found = 1'b0;
		free_way   = '0;
		cmd_hit    = '0;
		q_hit      = 1'b0;
		for (int w = 0; w < `PORT_WAYS; w++) begin
			if (!free_found && !way_valid[cmd_row][w]) begin  // First empty way wins
				free_found = 1'b1;
				free_way   = $bits(free_way)'(w);
			end
			if (way_valid[cmd_row][w] && way_port[cmd_row][w] == cmd.port)
				cmd_hit[w] = 1'b1;
			if (way_valid[q_row][w] && way_port[q_row][w] == query_port)
				q_hit = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			way_valid <= '{default: '0};
			port_open <= 1'b0;
		end else begin
			if (cmd.valid && cmd.open && free_found && cmd_hit == '0)
				way_valid[cmd_row][free_way] <= 1'b1;  // Full row ignores the open
			else if (cmd.valid && !cmd.open)
				way_valid[cmd_row] <= way_valid[cmd_row] & ~cmd_hit;
			if (query_valid)
				port_open <= q_hit;  // Held until the next query
		end
	end

	// Port numbers themselves, only meaningful where valid
	always_ff @(posedge clk) begin
		if (cmd.valid && cmd.open && free_found)
			way_port[cmd_row][free_way] <= cmd.port;
	end

endmodule

// File: logic/reply_fifo.sv
`timescale 1ns/100ps
`include "tcp_config.svh"

module reply_fifo (
	input  logic                   clk,
	input  logic                   rx_flag_rst,
	input  logic                   push,
	input  tcp_pkg::reply_event_t  din,
	input  logic                   pop,
	output logic                   valid,
	output tcp_pkg::reply_event_t  dout
);

	import tcp_pkg::*;

	localparam int ADDR_W = $clog2(`REPLY_FIFO_DEPTH);

	reply_event_t    mem [`REPLY_FIFO_DEPTH];
	logic [ADDR_W:0] wr_ptr;  // Extra bit tells full from empty
	logic [ADDR_W:0] rd_ptr;
	logic            full;

	assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
	assign valid = (wr_ptr != rd_ptr);
	assign dout  = mem[rd_ptr[ADDR_W-1:0]];  // Head entry

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;  // Lost when full, peer retransmits SYN
			if (pop && valid)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full)
			mem[wr_ptr[ADDR_W-1:0]] <= din;
	end

endmodule

// File: logic/reply_generator.sv
`timescale 1ns/100ps
`include "tcp_config.svh"

module reply_generator (
	input  logic                   clk,
	input  logic                   rx_flag_rst,
	input  logic                   reply_valid,
	input  tcp_pkg::reply_event_t  reply,
	output logic                   reply_pop,
	input  logic [31:0]            local_ip,
	output tcp_pkg::ip_tx_bus_t    tx_l3
);

	import tcp_pkg::*;

	logic           busy;
	logic [3:0]     cnt;     // Step within one reply, 0 is the pop cycle
	reply_event_t   evt;
	tcp_ctrl_word_u ctrl;
	logic           ck_load;
	logic           ck_process;
	logic [31:0]    ck_din;
	logic [15:0]    csum;

	// Control word, options never sent
	always_comb begin
		ctrl.f.data_offset = `TCP_HDR_WORDS;
		ctrl.f.reserved    = 6'b000000;
		ctrl.f.urg         = 1'b0;
		ctrl.f.ack         = evt.ack;
		ctrl.f.psh         = 1'b0;
		ctrl.f.tcp_rst     = evt.tcp_rst;
		ctrl.f.syn         = evt.syn;
		ctrl.f.fin         = 1'b0;
		ctrl.f.window      = `TCP_WINDOW;
	end

	//////////////////////////////////////////////////
	// Checksum feed, one word ahead of the bus

	always_comb begin
		case (cnt)
			4'd0:    ck_din = evt.remote_ip;
			4'd1:    ck_din = local_ip;
			4'd2:    ck_din = {8'h00, `IP_PROTO_TCP, `TCP_HDR_BYTES};  // Pseudo-header tail
			4'd3:    ck_din = {evt.local_port, evt.remote_port};
			4'd4:    ck_din = evt.seq;
			4'd5:    ck_din = evt.ack_num;
			4'd6:    ck_din = ctrl.raw;
			default: ck_din = 32'h0000_0000;
		endcase
	end

	assign ck_load    = busy && (cnt == 4'd0);
	assign ck_process = busy && (cnt >= 4'd1) && (cnt <= 4'd6);

	inet_checksum tx_csum (
		.clk         (clk),
		.rx_flag_rst (rx_flag_rst),
		.load        (ck_load),
		.process     (ck_process),
		.din         (ck_din),
		.csum        (csum)
	);

	//////////////////////////////////////////////////
	// Segment sequencing

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			busy      <= 1'b0;
			cnt       <= 4'd0;
			reply_pop <= 1'b0;
			tx_l3     <= '0;
		end else begin
			reply_pop        <= 1'b0;
			tx_l3.start      <= 1'b0;
			tx_l3.data_valid <= 1'b0;
			tx_l3.commit     <= 1'b0;
			if (!busy) begin
				if (reply_valid) begin
					reply_pop <= 1'b1;
					busy      <= 1'b1;
					cnt       <= 4'd0;
				end
			end else begin
				cnt <= cnt + 4'd1;
				if (cnt == 4'd3) begin  // First header word goes out with start
					tx_l3.start       <= 1'b1;
					tx_l3.dst_ip      <= evt.remote_ip;
					tx_l3.payload_len <= `TCP_HDR_BYTES;
					tx_l3.protocol    <= `IP_PROTO_TCP;
				end
				if (cnt >= 4'd3 && cnt <= 4'd6) begin
					tx_l3.data_valid  <= 1'b1;
					tx_l3.bytes_valid <= 3'd4;
					tx_l3.data        <= ck_din;
				end
				if (cnt == 4'd7) begin  // Sum over ctrl word ready now
					tx_l3.data_valid  <= 1'b1;
					tx_l3.bytes_valid <= 3'd4;
					tx_l3.data        <= {csum, 16'h0000};  // Urgent pointer zero
				end
				if (cnt == 4'd8) begin
					tx_l3.commit <= 1'b1;
					busy         <= 1'b0;
				end
			end
		end
	end

	// Head entry changes after the pop, keep a copy
	always_ff @(posedge clk) begin
		if (!busy && reply_valid)
			evt <= reply;
	end

endmodule

// File: logic/segment_parser.sv
`timescale 1ns/100ps
`include "tcp_config.svh"

module segment_parser (
	input  logic                   clk,
	input  logic                   rx_flag_rst,
	input  tcp_pkg::ip_rx_bus_t    rx_l3,
	input  logic [31:0]            local_ip,
	input  logic [31:0]            isn,
	input  logic                   port_open,
	output logic                   query_valid,
	output logic [15:0]            query_port,
	output logic                   reply_push,
	output tcp_pkg::reply_event_t  reply_event,
	output logic                   seg_drop
);

	import tcp_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE, S_PORTS, S_SEQ, S_ACK, S_CTRL, S_CSUM, S_OPTS, S_DATA, S_CHECK
	} rx_state_t;

	rx_state_t      state;
	logic           bad;       // Segment already doomed to a drop
	logic [3:0]     opt_cnt;
	tcp_ctrl_word_u ctrl;
	logic [31:0]    rem_ip;
	logic [15:0]    rem_port;
	logic [31:0]    rx_seq;
	logic [15:0]    csum;
	logic           in_hdr;
	logic           hdr_done;
	logic           syn_only;

	//////////////////////////////////////////////////
	// Checksum over pseudo-header and whole segment

	inet_checksum rx_csum (
		.clk         (clk),
		.rx_flag_rst (rx_flag_rst),
		.load        (rx_l3.start),
		.process     (rx_l3.data_valid),
		.din         (rx_l3.data_valid ? rx_l3.data : {16'h0000, rx_l3.pseudo_header_csum}),
		.csum        (csum)
	);

	assign in_hdr   = state inside {S_PORTS, S_SEQ, S_ACK, S_CTRL, S_CSUM, S_OPTS};
	// Header fully seen once this word is taken
	assign hdr_done = (state == S_DATA) || (rx_l3.data_valid &&
		((state == S_CSUM && ctrl.f.data_offset == `TCP_HDR_WORDS) ||
		 (state == S_OPTS && opt_cnt == ctrl.f.data_offset)));
	assign syn_only = ctrl.f.syn && !ctrl.f.ack && !ctrl.f.tcp_rst &&
		!ctrl.f.fin && !ctrl.f.urg && !ctrl.f.psh;

	//////////////////////////////////////////////////
	// Header walk and reply decision

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			state       <= S_IDLE;
			bad         <= 1'b0;
			opt_cnt     <= 4'd0;
			query_valid <= 1'b0;
			reply_push  <= 1'b0;
			seg_drop    <= 1'b0;
		end else begin
			query_valid <= 1'b0;
			reply_push  <= 1'b0;
			seg_drop    <= 1'b0;
			case (state)
				S_IDLE: if (rx_l3.start && rx_l3.protocol_is_tcp) begin  // Non-TCP never counted
					state <= S_PORTS;
					// Short payload, or our own address as source (LAND spoof)
					bad   <= (rx_l3.payload_len < `TCP_HDR_BYTES) || (rx_l3.src_ip == local_ip);
				end
				S_PORTS: if (rx_l3.data_valid) begin
					query_valid <= 1'b1;  // Port state back next cycle
					state       <= S_SEQ;
				end
				S_SEQ:  if (rx_l3.data_valid) state <= S_ACK;
				S_ACK:  if (rx_l3.data_valid) state <= S_CTRL;  // Their ack field unused
				S_CTRL: if (rx_l3.data_valid) state <= S_CSUM;
				S_CSUM: if (rx_l3.data_valid) begin
					opt_cnt <= `TCP_HDR_WORDS + 4'd1;
					state   <= (ctrl.f.data_offset > `TCP_HDR_WORDS) ? S_OPTS : S_DATA;
					if (ctrl.f.data_offset < `TCP_HDR_WORDS)
						bad <= 1'b1;  // Malformed offset
				end
				S_OPTS: if (rx_l3.data_valid) begin
					opt_cnt <= opt_cnt + 4'd1;
					if (opt_cnt == ctrl.f.data_offset)
						state <= S_DATA;
				end
				S_DATA: ;  // Payload only feeds the checksum
				S_CHECK: begin
					state <= S_IDLE;
					if (!bad && csum == 16'h0000 && syn_only)
						reply_push <= 1'b1;
					else
						seg_drop   <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase

			if (in_hdr && rx_l3.data_valid && rx_l3.bytes_valid != 3'd4)
				bad <= 1'b1;  // Truncated header word

			// Commit or abort from anywhere inside a segment
			if (state != S_IDLE && state != S_CHECK) begin
				if (rx_l3.commit) begin
					state <= S_CHECK;
					if (!hdr_done)
						bad <= 1'b1;
				end
				if (rx_l3.drop) begin
					state <= S_CHECK;
					bad   <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Captured header fields and outgoing event

	always_ff @(posedge clk) begin
		if (state == S_IDLE && rx_l3.start)
			rem_ip <= rx_l3.src_ip;
		if (state == S_PORTS && rx_l3.data_valid) begin
			rem_port   <= rx_l3.data[31:16];
			query_port <= rx_l3.data[15:0];  // Also our local port
		end
		if (state == S_SEQ && rx_l3.data_valid)
			rx_seq <= rx_l3.data;
		if (state == S_CTRL && rx_l3.data_valid)
			ctrl.raw <= rx_l3.data;
		if (state == S_CHECK) begin
			reply_event.remote_ip   <= rem_ip;
			reply_event.remote_port <= rem_port;
			reply_event.local_port  <= query_port;
			reply_event.syn         <= port_open;   // SYN+ACK when open
			reply_event.ack         <= 1'b1;
			reply_event.tcp_rst     <= !port_open;  // RST+ACK when closed
			reply_event.seq         <= isn;
			reply_event.ack_num     <= rx_seq + 32'd1;
		end
	end

endmodule

// File: logic/tcp_listener.sv
`timescale 1ns/100ps

module tcp_listener (
	input  logic                 clk,
	input  logic                 rx_flag_rst,
	input  tcp_pkg::ip_rx_bus_t  rx_l3,
	output tcp_pkg::ip_tx_bus_t  tx_l3,
	input  tcp_pkg::wb_req_t     wb_req,
	output tcp_pkg::wb_rsp_t     wb_rsp
);

	import tcp_pkg::*;

	port_cmd_t    port_cmd;
	logic [31:0]  local_ip;
	logic [31:0]  isn;
	logic         query_valid;
	logic [15:0]  query_port;
	logic         port_open;
	logic         reply_push;
	reply_event_t reply_event;
	logic         seg_drop;
	logic         reply_valid;
	reply_event_t reply_head;
	logic         reply_pop;

	//////////////////////////////////////////////////
	// Control plane

	listener_regs regs (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.wb_req(wb_req), .wb_rsp(wb_rsp), .port_cmd(port_cmd),
		.local_ip(local_ip), .isn(isn),
		.reply_push(reply_push), .seg_drop(seg_drop)
	);

	port_table port_tbl (
		.clk(clk), .rx_flag_rst(rx_flag_rst), .cmd(port_cmd),
		.query_valid(query_valid), .query_port(query_port), .port_open(port_open)
	);

	//////////////////////////////////////////////////
	// Receive, queue, transmit

	segment_parser parser (
		.clk(clk), .rx_flag_rst(rx_flag_rst), .rx_l3(rx_l3),
		.local_ip(local_ip), .isn(isn), .port_open(port_open),
		.query_valid(query_valid), .query_port(query_port),
		.reply_push(reply_push), .reply_event(reply_event), .seg_drop(seg_drop)
	);

	reply_fifo fifo (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.push(reply_push), .din(reply_event),
		.pop(reply_pop), .valid(reply_valid), .dout(reply_head)
	);

	reply_generator gen (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.reply_valid(reply_valid), .reply(reply_head), .reply_pop(reply_pop),
		.local_ip(local_ip), .tx_l3(tx_l3)
	);

endmodule

// File: logic/tcp_pkg.sv
package tcp_pkg;

	// Inbound segment stream from the IPv4 layer
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
		logic        commit;
		logic        drop;
		logic [31:0] src_ip;
		logic [15:0] payload_len;
		logic        protocol_is_tcp;
		logic [15:0] pseudo_header_csum;  // Partial sum over the pseudo-header
	} ip_rx_bus_t;

	// Outbound segment stream to the IPv4 layer
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
		logic        commit;
		logic [31:0] dst_ip;
		logic [15:0] payload_len;
		logic [7:0]  protocol;
	} ip_tx_bus_t;

	// One header-only reply waiting to go out
	typedef struct packed {
		logic [31:0] remote_ip;
		logic [15:0] remote_port;
		logic [15:0] local_port;
		logic        syn;
		logic        ack;
		logic        tcp_rst;
		logic [31:0] seq;
		logic [31:0] ack_num;
	} reply_event_t;

	// Fourth TCP header word, offset / flags / window
	typedef struct packed {
		logic [3:0]  data_offset;  // In 32-bit words
		logic [5:0]  reserved;
		logic        urg;
		logic        ack;
		logic        psh;
		logic        tcp_rst;
		logic        syn;
		logic        fin;
		logic [15:0] window;
	} tcp_ctrl_t;

	typedef union packed {
		logic [31:0] raw;
		tcp_ctrl_t   f;
	} tcp_ctrl_word_u;

	// Wishbone classic
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

	// Open or close one port
	typedef struct packed {
		logic        valid;
		logic        open;
		logic [15:0] port;
	} port_cmd_t;

endpackage

// File: tcp_listener.f
+incdir+include
logic/tcp_pkg.sv
logic/inet_checksum.sv
logic/port_table.sv
logic/listener_regs.sv
logic/segment_parser.sv
logic/reply_fifo.sv
logic/reply_generator.sv
logic/tcp_listener.sv
dv/tcp_listener_tb.sv
